/* Bender.yml */
package:
  name: pov_display

sources:
  - logic/pov_pkg.sv
  - logic/position_detector.sv
  - logic/frame_loader.sv
  - logic/slice_fetcher.sv
  - logic/column_arbiter.sv
  - logic/frame_memory.sv
  - logic/pov_display_top.sv
  - target: test
    files:
      - testbench/pov_display_tb.sv

/* build.f */
logic/pov_pkg.sv
logic/position_detector.sv
logic/frame_loader.sv
logic/slice_fetcher.sv
logic/column_arbiter.sv
logic/frame_memory.sv
logic/pov_display_top.sv
testbench/pov_display_tb.sv

/* logic/column_arbiter.sv */
////////////////////////////////////////////////////////////
// Requesters hold a request until granted, grants last one cycle
////////////////////////////////////////////////////////////
module column_arbiter import pov_pkg::*; (
    input  logic     clk,
    input  logic     nrst,
    input  mem_req_t fetch_req,
    input  mem_req_t load_req,
    output logic     fetch_gnt,
    output logic     load_gnt,
    output mem_req_t mem_req
);

    logic fetch_win;
    logic load_win;

    // A requester sees its grant one cycle late and still shows the
    // same request then, so a live grant blocks it from winning again
    assign fetch_win = fetch_req.valid && !fetch_gnt;

    // The display must not miss slices so the host waits
    assign load_win = load_req.valid && !load_gnt && !fetch_win;

    // Grant and memory request leave on the same edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fetch_gnt <= 1'b0;
            load_gnt  <= 1'b0;
            mem_req   <= '0;
        end else begin
            fetch_gnt <= fetch_win;
            load_gnt  <= load_win;
            if (fetch_win) begin
                mem_req <= fetch_req;
            end else if (load_win) begin
                mem_req <= load_req;
            end else begin
                mem_req.valid <= 1'b0;
            end
        end
    end

    // A request that lost arbitration must still be there on the next cycle
    fetch_held_until_grant: assert property (
        @(posedge clk) disable iff (!nrst)
        (fetch_req.valid && !fetch_gnt) |=> fetch_req.valid
    );

    // The loader waits behind the fetcher without dropping its write
    load_held_until_grant: assert property (
        @(posedge clk) disable iff (!nrst)
        (load_req.valid && !load_gnt) |=> load_req.valid
    );

endmodule

/* logic/frame_loader.sv */
////////////////////////////////////////////////////////////
// Host must hold slice and column stable while host_req is high
////////////////////////////////////////////////////////////
module frame_loader import pov_pkg::*; (
    input  logic     clk,
    input  logic     nrst,
    input  logic     host_req,
    input  slice_t   host_slice,
    input  column_t  host_column,
    output logic     host_ack,
    output mem_req_t load_req,
    input  logic     load_gnt
);

    logic [1:0] state;

    // One write per handshake then wait for the host to release
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= LOAD_IDLE;
        end else begin
            case (state)
                LOAD_IDLE:  if (host_req) state <= LOAD_WRITE;
                LOAD_WRITE: if (load_gnt) state <= LOAD_ACK;
                LOAD_ACK:   if (!host_req) state <= LOAD_IDLE;
                default:    state <= LOAD_IDLE;
            endcase
        end
    end

    // The host data goes straight to the arbiter since it is held stable
    assign load_req.valid = (state == LOAD_WRITE);
    assign load_req.write = 1'b1;
    assign load_req.addr  = host_slice;
    assign load_req.wdata = host_column;

    // Acknowledge only once the memory has taken the write
    assign host_ack = (state == LOAD_ACK);

    // A host that drops its request early breaks the four-phase protocol
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!nrst) $rose(host_ack) |-> host_req
    );

endmodule

/* logic/frame_memory.sv */
////////////////////////////////////////////////////////////
// Contents are undefined until written, reads take one cycle
////////////////////////////////////////////////////////////
module frame_memory import pov_pkg::*; (
    input  logic     clk,
    input  mem_req_t mem_req,
    output column_t  rdata
);

    // One LED column per angular slice
    column_t mem [SLICES_PER_TURN];

    // Single port so a cycle either writes or reads
    // rdata keeps the last read value between reads
    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            if (mem_req.write) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];
            end
        end
    end

endmodule

/* logic/position_detector.sv */
////////////////////////////////////////////////////////////
// Hall inputs must already be synchronised to clk
// The first half turn after reset has no slice pulses past its top
////////////////////////////////////////////////////////////
module position_detector import pov_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        hall_1,
    input  logic        hall_2,
    output slice_t      slice_cnt,
    output logic        position_sync,
    output logic [31:0] speed_data
);

    // One-cycle pulse on the first cycle a sensor reads low
    logic top;

    // Set by a top and held until both sensors are released
    logic guard;

    // Low after a hall_1 top and high after a hall_2 top
    logic second_half;

    // Cycles elapsed since the last top
    logic [31:0] half_turn_cycles;

    // Cycles per slice measured over the previous half turn
    logic [31-HALF_TURN_SHIFT:0] slice_period;
    logic [31-HALF_TURN_SHIFT:0] slice_cycles;

    // Slice index within the current half turn
    logic [HALF_TURN_SHIFT-1:0] slice_half_cnt;

    // The current slice has lasted its full period and another may follow
    logic slice_due;

    // A zero period means no half turn has been measured yet
    assign slice_due = (slice_period != '0)
                    && (slice_cycles == slice_period - 1'b1)
                    && (slice_half_cnt != HALF_TURN_SHIFT'(SLICES_PER_HALF_TURN - 1));

    // Either sensor starts a top but only once per pass
    // hall_1 wins when both fall together
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            top         <= 1'b0;
            guard       <= 1'b0;
            second_half <= 1'b0;
        end else begin
            top <= 1'b0;
            if ((!hall_1 || !hall_2) && !guard) begin
                top         <= 1'b1;
                guard       <= 1'b1;
                second_half <= hall_1;
            end
            if (hall_1 && hall_2) begin
                guard <= 1'b0;
            end
        end
    end

    // Half turn measurement and speed report
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            half_turn_cycles <= '0;
            slice_period     <= '0;
            speed_data       <= '0;
        end else if (top) begin
            // The counter restarts at 1 so it holds N on a top N cycles later
            half_turn_cycles <= 32'd1;
            slice_period     <= half_turn_cycles[31:HALF_TURN_SHIFT];
            speed_data       <= {half_turn_cycles[30:0], 1'b0};
        end else begin
            half_turn_cycles <= half_turn_cycles + 32'd1;
        end
    end

    // Slice pulses are restarted at every top
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            position_sync  <= 1'b0;
            slice_cycles   <= '0;
            slice_half_cnt <= '0;
        end else begin
            position_sync <= 1'b0;
            if (top) begin
                // The top itself marks slice 0 of the new half turn
                position_sync  <= 1'b1;
                slice_cycles   <= '0;
                slice_half_cnt <= '0;
            end else if (slice_due) begin
                position_sync  <= 1'b1;
                slice_cycles   <= '0;
                slice_half_cnt <= slice_half_cnt + 1'b1;
            end else begin
                slice_cycles <= slice_cycles + 1'b1;
            end
        end
    end

    // The half-turn flag becomes the top bit of the full-turn index
    assign slice_cnt = {second_half, slice_half_cnt};

    // Slices are at least two cycles long for any real rotor speed
    sync_not_back_to_back: assert property (
        @(posedge clk) disable iff (!nrst) position_sync |=> !position_sync
    );

endmodule

/* logic/pov_display_top.sv */
////////////////////////////////////////////////////////////
// Hall inputs are active low and must be synchronous to clk
////////////////////////////////////////////////////////////
module pov_display_top import pov_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        hall_1,
    input  logic        hall_2,
    input  logic        host_req,
    input  slice_t      host_slice,
    input  column_t     host_column,
    output logic        host_ack,
    output logic [31:0] speed_data,
    output column_t     led_column,
    output slice_t      column_slice,
    output logic        column_strobe
);

    // Rotor position toward the fetcher
    slice_t slice_cnt;
    logic   position_sync;

    // Both masters of the frame memory and the arbitrated result
    mem_req_t load_req;
    mem_req_t fetch_req;
    mem_req_t mem_req;
    logic     load_gnt;
    logic     fetch_gnt;
    column_t  rdata;

    position_detector u_position_detector (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync),
        .speed_data    (speed_data)
    );

    frame_loader u_frame_loader (
        .clk         (clk),
        .nrst        (nrst),
        .host_req    (host_req),
        .host_slice  (host_slice),
        .host_column (host_column),
        .host_ack    (host_ack),
        .load_req    (load_req),
        .load_gnt    (load_gnt)
    );

    slice_fetcher u_slice_fetcher (
        .clk           (clk),
        .nrst          (nrst),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync),
        .fetch_req     (fetch_req),
        .fetch_gnt     (fetch_gnt),
        .rdata         (rdata),
        .led_column    (led_column),
        .column_slice  (column_slice),
        .column_strobe (column_strobe)
    );

    column_arbiter u_column_arbiter (
        .clk       (clk),
        .nrst      (nrst),
        .fetch_req (fetch_req),
        .load_req  (load_req),
        .fetch_gnt (fetch_gnt),
        .load_gnt  (load_gnt),
        .mem_req   (mem_req)
    );

    frame_memory u_frame_memory (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

/* logic/pov_pkg.sv */
////////////////////////////////////////////////////////////
// Sizes are fixed for a 256-slice rotor with 32 LEDs per column
// HALF_TURN_SHIFT must stay the log2 of SLICES_PER_HALF_TURN
////////////////////////////////////////////////////////////
package pov_pkg;

    // Angular resolution of one full turn of the rotor
    localparam int SLICES_PER_TURN = 256;

    // Each Hall sensor top starts a new half turn of this many slices
    localparam int SLICES_PER_HALF_TURN = 128;

    // Dividing the cycles of a half turn by 2**7 gives the cycles of one slice
    localparam int HALF_TURN_SHIFT = 7;

    // Number of LEDs along the blade
    localparam int COLUMN_WIDTH = 32;

    // A slice index over the full turn doubles as the frame memory address
    typedef logic [$clog2(SLICES_PER_TURN)-1:0] slice_t;

    // One bit per LED, a set bit lights the LED
    typedef logic [COLUMN_WIDTH-1:0] column_t;

    // A single request toward the frame memory
    // Reads ignore wdata
    typedef struct packed {
        logic    valid;
        logic    write;
        slice_t  addr;
        column_t wdata;
    } mem_req_t;

    // Host loader FSM encodings
    localparam logic [1:0] LOAD_IDLE  = 2'd0;
    localparam logic [1:0] LOAD_WRITE = 2'd1;
    localparam logic [1:0] LOAD_ACK   = 2'd2;

endpackage

/* logic/slice_fetcher.sv */
////////////////////////////////////////////////////////////
// Holds one pending slice, a newer sync overwrites it
////////////////////////////////////////////////////////////
module slice_fetcher import pov_pkg::*; (
    input  logic     clk,
    input  logic     nrst,
    input  slice_t   slice_cnt,
    input  logic     position_sync,
    output mem_req_t fetch_req,
    input  logic     fetch_gnt,
    input  column_t  rdata,
    output column_t  led_column,
    output slice_t   column_slice,
    output logic     column_strobe
);

    // Read waiting for its grant
    logic   req_valid;
    slice_t req_slice;

    // Granted read whose data arrives this cycle
    logic rd_wait;

    // Sync that arrived while a read was already queued
    logic   pend_valid;
    slice_t pend_slice;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_valid     <= 1'b0;
            rd_wait       <= 1'b0;
            pend_valid    <= 1'b0;
            led_column    <= '0;
            column_slice  <= '0;
            column_strobe <= 1'b0;
        end else begin
            column_strobe <= 1'b0;
            rd_wait       <= 1'b0;
            if (fetch_gnt) begin
                req_valid <= 1'b0;
                rd_wait   <= 1'b1;
            end else if (!req_valid) begin
                // The older pending slice is served before a fresh sync
                if (pend_valid) begin
                    req_valid  <= 1'b1;
                    req_slice  <= pend_slice;
                    pend_valid <= 1'b0;
                end else if (position_sync) begin
                    req_valid <= 1'b1;
                    req_slice <= slice_cnt;
                end
            end
            if (position_sync && (req_valid || pend_valid)) begin
                pend_valid <= 1'b1;
                pend_slice <= slice_cnt;
            end
            // req_slice still names the granted read here
            if (rd_wait) begin
                led_column    <= rdata;
                column_slice  <= req_slice;
                column_strobe <= 1'b1;
            end
        end
    end

    assign fetch_req.valid = req_valid;
    assign fetch_req.write = 1'b0;
    assign fetch_req.addr  = req_slice;
    assign fetch_req.wdata = '0;

endmodule

/* testbench/pov_display_cases.txt */
// half_turn_cycles first_sensor low_cycles pair_count then three slice column pairs
// All words in hex, a line of zeros ends the list
00000700 1 010 3 05 deadbeef 85 00ff00ff 40 80000001
00000700 2 258 2 c0 12345678 03 a5a5a5a5 00 00000000
00000780 1 008 3 7f ffffffff ff 0f0f0f0f 80 f0f0f0f0
00000800 2 014 3 10 cafef00d 90 13572468 01 fedcba98
00000000 0 000 0 00 00000000 00 00000000 00 00000000

/* testbench/pov_display_tb.sv */
////////////////////////////////////////////////////////////
// Cases must list half turns in non-decreasing length, each a multiple of 128
// Low times must stay shorter than the half turn
////////////////////////////////////////////////////////////
module pov_display_tb import pov_pkg::*; ();

    // Words per line of the case file, see the file's own column note
    localparam int CASE_WORDS = 10;
    localparam int MAX_CASES  = 8;

    logic        clk;
    logic        nrst;
    logic        hall_1;
    logic        hall_2;
    logic        host_req;
    slice_t      host_slice;
    column_t     host_column;
    logic        host_ack;
    logic [31:0] speed_data;
    column_t     led_column;
    slice_t      column_slice;
    logic        column_strobe;

    logic [31:0] cases [CASE_WORDS*MAX_CASES];

    // What the frame memory should hold after every finished handshake
    column_t model [SLICES_PER_TURN];

    int          pass_count;
    int          fail_count;
    int          cycle;
    int          last_fall;
    int          half_strobes;
    int          tops_seen;
    int          rand_seed;
    logic        origin_pending;
    slice_t      origin_slice;
    logic        tracking;
    slice_t      exp_slice;
    logic        ack_seen;
    logic        speed_known;
    logic [31:0] exp_speed;

    pov_display_top UUT (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .host_req      (host_req),
        .host_slice    (host_slice),
        .host_column   (host_column),
        .host_ack      (host_ack),
        .speed_data    (speed_data),
        .led_column    (led_column),
        .column_slice  (column_slice),
        .column_strobe (column_strobe)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Free running count of rising edges, read only on falling edges
    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        fail_count++;
    endtask

    task automatic check_column(input string name, input column_t got, input column_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end else begin
            $display("ok       %s = %h", name, got);
            pass_count++;
        end
    endtask

    task automatic check_slice(input string name, input slice_t got, input slice_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end else begin
            $display("ok       %s = %h", name, got);
            pass_count++;
        end
    endtask

    task automatic check_speed(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch speed_data: got %h, expected %h", got, exp);
            fail_count++;
        end else begin
            $display("ok       speed_data = %h", got);
            pass_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end else begin
            $display("ok       %s = %h", name, got);
            pass_count++;
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("column_strobe", column_strobe, 1'b0);
        check_flag("host_ack", host_ack, 1'b0);
        check_speed(speed_data, 32'h0);
        check_column("led_column", led_column, '0);
    endtask

    // Strobes are checked before the model takes a write seen in the same cycle,
    // since a read that beat the write shows the old column
    always @(negedge clk) begin
        if (nrst && column_strobe) begin
            if (origin_pending) begin
                check_slice("column_slice at top", column_slice, origin_slice);
                origin_pending = 1'b0;
                tracking       = 1'b1;
                exp_slice      = origin_slice + 1'b1;
                half_strobes   = 1;
            end else if (!tracking) begin
                report_failure("a column strobe came before any sensor top");
            end else begin
                check_slice("column_slice", column_slice, exp_slice);
                exp_slice = exp_slice + 1'b1;
                half_strobes++;
                if (half_strobes > SLICES_PER_HALF_TURN)
                    report_failure("more than 128 column strobes in one half turn");
            end
            check_column("led_column", led_column, model[column_slice]);
        end
        if (nrst && host_ack && !ack_seen)
            model[host_slice] = host_column;
        ack_seen = host_ack;
    end

    // One full four-phase handshake
    task automatic host_write(input slice_t slice, input column_t column);
        int wait_cycles;
        @(posedge clk);
        host_req    <= 1'b1;
        host_slice  <= slice;
        host_column <= column;
        wait_cycles = 0;
        @(negedge clk);
        while (!host_ack && wait_cycles < 200) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!host_ack)
            report_failure($sformatf("host_ack never rose for a write to slice %h", slice));
        @(posedge clk);
        host_req <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (host_ack && wait_cycles < 200) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_flag("host_ack after release", host_ack, 1'b0);
    endtask

    // Drops one sensor for low_len cycles and returns len cycles after the drop
    task automatic half_turn(input int sensor, input int low_len, input int len);
        int fall;
        @(posedge clk);
        // A half turn with a measured period shows every one of its slices
        if (tops_seen >= 2) begin
            if (half_strobes != SLICES_PER_HALF_TURN) begin
                report_failure($sformatf("the last half turn gave %0d column strobes, not 128",
                                         half_strobes));
            end else begin
                $display("ok       %0d column strobes in the last half turn", half_strobes);
                pass_count++;
            end
        end
        tops_seen++;
        if (sensor == 1)
            hall_1 <= 1'b0;
        else
            hall_2 <= 1'b0;
        origin_slice   = (sensor == 1) ? slice_t'(0) : slice_t'(SLICES_PER_HALF_TURN);
        origin_pending = 1'b1;
        @(negedge clk);
        fall = cycle;
        while (origin_pending && cycle - fall < 20) @(negedge clk);
        if (origin_pending)
            report_failure("no column strobe followed the sensor top");
        // Speed is twice the rising edges between two drops
        if (last_fall >= 0) begin
            exp_speed   = 32'(2 * (fall - last_fall));
            speed_known = 1'b1;
            check_speed(speed_data, exp_speed);
        end
        last_fall = fall;
        while (cycle - fall < low_len - 1) @(negedge clk);
        // A held sensor must not retrigger the speed measurement
        if (speed_known)
            check_speed(speed_data, exp_speed);
        @(posedge clk);
        hall_1 <= 1'b1;
        hall_2 <= 1'b1;
        @(negedge clk);
        while (cycle - fall < len - 1) @(negedge clk);
    endtask

    task automatic load_columns(input int base);
        int k;
        // Start mid-rotation so that writes compete with fetches
        repeat (100) @(posedge clk);
        for (k = 0; k < cases[base+3]; k++)
            host_write(cases[base+4+2*k][7:0], cases[base+5+2*k]);
    endtask

    task automatic run_case(input int base);
        int first;
        first = cases[base+1];
        fork
            begin
                half_turn(first, cases[base+2], cases[base]);
                half_turn(3 - first, cases[base+2], cases[base]);
                half_turn(first, cases[base+2], cases[base]);
            end
            load_columns(base);
        join
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    endtask

    initial begin
        int num_cases;
        int limit;
        int s;
        nrst        <= 1'b0;
        hall_1      <= 1'b1;
        hall_2      <= 1'b1;
        host_req    <= 1'b0;
        host_slice  <= '0;
        host_column <= '0;
        cycle          = 0;
        pass_count     = 0;
        fail_count     = 0;
        last_fall      = -1;
        half_strobes   = 0;
        tops_seen      = 0;
        origin_pending = 1'b0;
        tracking       = 1'b0;
        ack_seen       = 1'b0;
        speed_known    = 1'b0;
        rand_seed      = 32'h776c;
        void'($urandom(rand_seed));
        $readmemh("testbench/pov_display_cases.txt", cases);
        num_cases = 0;
        limit     = 2000;
        while (num_cases < MAX_CASES && cases[num_cases*CASE_WORDS] != 0) begin
            limit += 4 * cases[num_cases*CASE_WORDS];
            num_cases++;
        end
        if (num_cases == 0)
            report_failure("the case file held no cases");
        fork
            watchdog(limit);
        join_none
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_idle_outputs();
        // A first top right after reset measures no period, so loading runs undisturbed
        if (num_cases > 0) begin
            fork
                half_turn(2, 4, cases[0]);
                for (s = 0; s < SLICES_PER_TURN; s++)
                    host_write(slice_t'(s), $urandom());
            join
        end
        for (s = 0; s < num_cases; s++)
            run_case(s * CASE_WORDS);
        @(negedge clk);
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
